// File: src/radio_pkg.sv
// Shared types and constants for the radio control core.
// Setting addresses, readback select codes and the setting bus
// struct used by every pipeline stage. Import where needed.

package radio_pkg;

   //////////////////////////////
   // Basic word types
   //////////////////////////////

   typedef logic [7:0]  sr_addr_t;

   // I in the upper half, Q in the lower half
   typedef logic [31:0] sample_t;

   typedef logic [63:0] radio_time_t;
   typedef logic [63:0] rb_word_t;

   // One setting command, external input and internal bus alike
   typedef struct packed {
      sr_addr_t    addr;
      logic [31:0] data;
   } set_bus_t;

   //////////////////////////////
   // Setting addresses
   //////////////////////////////

   localparam sr_addr_t SR_LOOPBACK   = 8'd6;
   localparam sr_addr_t SR_TEST       = 8'd21;
   localparam sr_addr_t SR_CODEC_IDLE = 8'd22;
   localparam sr_addr_t SR_READBACK   = 8'd32;

   // Time registers sit at base, base+1 and base+2
   localparam sr_addr_t SR_TIME_BASE_DEFAULT = 8'd128;

   //////////////////////////////
   // Readback select codes
   //////////////////////////////

   localparam int RB_SEL_W = 3;

   localparam logic [RB_SEL_W-1:0] RB_TEST  = 3'd0;
   localparam logic [RB_SEL_W-1:0] RB_TIME  = 3'd1;
   localparam logic [RB_SEL_W-1:0] RB_CODEC = 3'd3;

endpackage

// File: src/radio_ctrl_decode.sv
// Command input stage of the radio control core.
// Registers a strobed setting command onto the internal setting bus,
// one cycle after it arrives. The bus data is held between strobes.

`timescale 1ns/10ps

module radio_ctrl_decode (
   input  logic               bus_clk,
   input  logic               i_reset,
   input  logic               i_set_stb,
   input  radio_pkg::set_bus_t i_set,
   output logic               o_set_stb,
   output radio_pkg::set_bus_t o_set
);

   // Strobe follows the input one cycle later
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_set_stb <= 1'b0;
      end else begin
         o_set_stb <= i_set_stb;
      end
   end

   // Only capture address and data on a real command,
   // so idle cycles never put garbage on the bus
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_set <= '0;
      end else if (i_set_stb) begin
         o_set <= i_set;
      end
   end

endmodule

// File: src/radio_settings.sv
// Radio setting registers.
// Holds loopback, test word, codec idle word and readback select.
// Each register loads on a strobe with a matching address. The
// strobe is delayed one cycle here to launch the readback stage.

`timescale 1ns/10ps

module radio_settings (
   input  logic                              bus_clk,
   input  logic                              i_reset,
   input  logic                              i_set_stb,
   input  radio_pkg::set_bus_t               i_set,
   output logic                              o_loopback,
   output logic [31:0]                       o_test,
   output radio_pkg::sample_t                o_codec_idle,
   output logic [radio_pkg::RB_SEL_W-1:0]    o_rb_sel,
   output logic                              o_rb_stb
);

   import radio_pkg::*;

   logic wr_loopback;
   logic wr_test;
   logic wr_codec_idle;
   logic wr_readback;

   // Address match per register
   assign wr_loopback   = i_set_stb && (i_set.addr == SR_LOOPBACK);
   assign wr_test       = i_set_stb && (i_set.addr == SR_TEST);
   assign wr_codec_idle = i_set_stb && (i_set.addr == SR_CODEC_IDLE);
   assign wr_readback   = i_set_stb && (i_set.addr == SR_READBACK);

   //////////////////////////////
   // Setting registers
   //////////////////////////////

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_loopback   <= 1'b0;
         o_test       <= '0;
         o_codec_idle <= '0;
         o_rb_sel     <= '0;
      end else begin
         if (wr_loopback) begin
            o_loopback <= i_set.data[0];
         end
         if (wr_test) begin
            o_test <= i_set.data;
         end
         if (wr_codec_idle) begin
            o_codec_idle <= i_set.data;
         end
         if (wr_readback) begin
            o_rb_sel <= i_set.data[RB_SEL_W-1:0];
         end
      end
   end

   // Readback launches in the cycle the new values become visible
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_rb_stb <= 1'b0;
      end else begin
         o_rb_stb <= i_set_stb;
      end
   end

endmodule

// File: src/radio_timekeeper.sv
// Free-running 64-bit radio time counter, settable over the setting bus.
// base+0 stores a pending high word, base+1 loads the counter with
// the pending high word above the written low word, base+2 clears
// the pending high word. The counter advances every cycle otherwise.

`timescale 1ns/10ps

module radio_timekeeper #(
   parameter radio_pkg::sr_addr_t SR_TIME_BASE = radio_pkg::SR_TIME_BASE_DEFAULT
) (
   input  logic                  bus_clk,
   input  logic                  i_reset,
   input  logic                  i_set_stb,
   input  radio_pkg::set_bus_t   i_set,
   output radio_pkg::radio_time_t o_vita_time
);

   import radio_pkg::*;

   localparam sr_addr_t SR_TIME_HI   = SR_TIME_BASE;
   localparam sr_addr_t SR_TIME_LO   = SR_TIME_BASE + 8'd1;
   localparam sr_addr_t SR_TIME_CTRL = SR_TIME_BASE + 8'd2;

   logic [31:0] pending_hi;

   // Pending high word, waits for the low word write
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         pending_hi <= '0;
      end else if (i_set_stb && (i_set.addr == SR_TIME_HI)) begin
         pending_hi <= i_set.data;
      end else if (i_set_stb && (i_set.addr == SR_TIME_CTRL)) begin
         pending_hi <= '0;
      end
   end

   // Tick counter, low word write commits the full value
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_vita_time <= '0;
      end else if (i_set_stb && (i_set.addr == SR_TIME_LO)) begin
         o_vita_time <= {pending_hi, i_set.data};
      end else begin
         o_vita_time <= o_vita_time + 64'd1;
      end
   end

endmodule

// File: src/radio_frontend.sv
// Codec-side sample registers.
// TX drives the sample while running and the idle word otherwise.
// The receive front end takes RX, or the TX word when looped back.

`timescale 1ns/10ps

module radio_frontend (
   input  logic               bus_clk,
   input  logic               i_reset,
   input  radio_pkg::sample_t i_tx_sample,
   input  logic               i_tx_run,
   input  radio_pkg::sample_t i_rx,
   input  logic               i_loopback,
   input  radio_pkg::sample_t i_codec_idle,
   output radio_pkg::sample_t o_tx,
   output radio_pkg::sample_t o_rx_fe
);

   // Codec output word
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_tx <= '0;
      end else begin
         o_tx <= i_tx_run ? i_tx_sample : i_codec_idle;
      end
   end

   // Digital loopback takes the registered TX word
   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_rx_fe <= '0;
      end else begin
         o_rx_fe <= i_loopback ? o_tx : i_rx;
      end
   end

endmodule

// File: src/radio_readback.sv
// Readback stage of the command pipeline.
// Picks the 64-bit readback word by the select register and
// registers it together with the response strobe. One response
// leaves for every strobe that comes in.

`timescale 1ns/10ps

module radio_readback (
   input  logic                           bus_clk,
   input  logic                           i_reset,
   input  logic                           i_rb_stb,
   input  logic [radio_pkg::RB_SEL_W-1:0] i_rb_sel,
   input  logic [31:0]                    i_test,
   input  radio_pkg::radio_time_t         i_vita_time,
   input  radio_pkg::sample_t             i_tx,
   input  radio_pkg::sample_t             i_rx,
   output logic                           o_resp_stb,
   output radio_pkg::rb_word_t            o_resp
);

   import radio_pkg::*;

   rb_word_t rb_data;

   // Readback mux, unused codes read zero
   always_comb begin
      case (i_rb_sel)
         RB_TEST:  rb_data = {32'd0, i_test};
         RB_TIME:  rb_data = i_vita_time;
         RB_CODEC: rb_data = {i_tx, i_rx};
         default:  rb_data = '0;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_resp_stb <= 1'b0;
      end else begin
         o_resp_stb <= i_rb_stb;
      end
   end

   // Response word holds until the next readback
   always_ff @(posedge bus_clk) begin
      if (i_rb_stb) begin
         o_resp <= rb_data;
      end
   end

endmodule

// File: src/radio_core.sv
// Top level of the radio control core.
// Commands pass decode, settings and readback, three cycles from
// command strobe to response strobe. The timekeeper and the codec
// front end run alongside on the same setting bus and clock.

`timescale 1ns/10ps

module radio_core #(
   parameter radio_pkg::sr_addr_t SR_TIME_BASE = radio_pkg::SR_TIME_BASE_DEFAULT
) (
   input  logic                   bus_clk,
   input  logic                   i_reset,
   input  logic                   i_set_stb,
   input  radio_pkg::set_bus_t    i_set,
   input  radio_pkg::sample_t     i_tx_sample,
   input  logic                   i_tx_run,
   input  radio_pkg::sample_t     i_rx,
   output radio_pkg::sample_t     o_tx,
   output radio_pkg::sample_t     o_rx_fe,
   output radio_pkg::radio_time_t o_vita_time,
   output logic                   o_resp_stb,
   output radio_pkg::rb_word_t    o_resp
);

   import radio_pkg::*;

   // Internal setting bus
   logic     set_stb;
   set_bus_t set;

   // Register outputs
   logic                cfg_loopback;
   logic [31:0]         cfg_test;
   sample_t             cfg_codec_idle;
   logic [RB_SEL_W-1:0] cfg_rb_sel;
   logic                rb_stb;

   //////////////////////////////
   // Command pipeline
   //////////////////////////////

   radio_ctrl_decode decode_i (
      .bus_clk   (bus_clk),
      .i_reset   (i_reset),
      .i_set_stb (i_set_stb),
      .i_set     (i_set),
      .o_set_stb (set_stb),
      .o_set     (set)
   );

   radio_settings settings_i (
      .bus_clk      (bus_clk),
      .i_reset      (i_reset),
      .i_set_stb    (set_stb),
      .i_set        (set),
      .o_loopback   (cfg_loopback),
      .o_test       (cfg_test),
      .o_codec_idle (cfg_codec_idle),
      .o_rb_sel     (cfg_rb_sel),
      .o_rb_stb     (rb_stb)
   );

   radio_readback readback_i (
      .bus_clk     (bus_clk),
      .i_reset     (i_reset),
      .i_rb_stb    (rb_stb),
      .i_rb_sel    (cfg_rb_sel),
      .i_test      (cfg_test),
      .i_vita_time (o_vita_time),
      .i_tx        (o_tx),
      .i_rx        (i_rx),
      .o_resp_stb  (o_resp_stb),
      .o_resp      (o_resp)
   );

   //////////////////////////////
   // Time and codec side
   //////////////////////////////

   radio_timekeeper #(
      .SR_TIME_BASE (SR_TIME_BASE)
   ) timekeeper_i (
      .bus_clk     (bus_clk),
      .i_reset     (i_reset),
      .i_set_stb   (set_stb),
      .i_set       (set),
      .o_vita_time (o_vita_time)
   );

   radio_frontend frontend_i (
      .bus_clk      (bus_clk),
      .i_reset      (i_reset),
      .i_tx_sample  (i_tx_sample),
      .i_tx_run     (i_tx_run),
      .i_rx         (i_rx),
      .i_loopback   (cfg_loopback),
      .i_codec_idle (cfg_codec_idle),
      .o_tx         (o_tx),
      .o_rx_fe      (o_rx_fe)
   );

endmodule

// File: bench/radio_core_assertions.sv
// Pipeline timing checks for the radio control core.
// Bound to radio_core. Every command strobe is answered by exactly
// one response strobe three cycles later, and reset keeps it low.

`timescale 1ns/10ps

module radio_core_assertions (
   input logic bus_clk,
   input logic i_reset,
   input logic i_set_stb,
   input logic o_resp_stb
);

   // Command in cycle N, response in cycle N+3
   property resp_follows_cmd;
      @(posedge bus_clk) disable iff (i_reset)
         i_set_stb |-> ##3 o_resp_stb;
   endproperty

   // No response without a command three cycles back
   property resp_needs_cmd;
      @(posedge bus_clk) disable iff (i_reset)
         o_resp_stb |-> $past(i_set_stb, 3);
   endproperty

   property resp_low_in_reset;
      @(posedge bus_clk) i_reset |=> !o_resp_stb;
   endproperty

   resp_follows_cmd_a: assert property (resp_follows_cmd)
      else $error("Response strobe missing three cycles after a command");
   resp_needs_cmd_a: assert property (resp_needs_cmd)
      else $error("Response strobe without a command three cycles earlier");
   resp_low_in_reset_a: assert property (resp_low_in_reset)
      else $error("Response strobe high during reset");

endmodule

// File: bench/radio_core_tb.sv
// Testbench for the radio control core.
// Drives random setting commands, TX samples and RX words from a fixed
// seed and checks every output cycle by cycle against a reference model.
// Responses are queued by the model and matched in order. A second reset
// halfway through the run cuts off commands still in the pipeline.

`timescale 1ns/10ps

module radio_core_tb;

   import radio_pkg::*;

   localparam int       CLK_PERIOD   = 8;
   localparam int       RESET_CYCLES = 16;
   localparam int       NUM_CMDS     = 1500;
   localparam sr_addr_t TIME_HI_ADDR  = SR_TIME_BASE_DEFAULT;
   localparam sr_addr_t TIME_LO_ADDR  = SR_TIME_BASE_DEFAULT + 8'd1;
   localparam sr_addr_t TIME_CLR_ADDR = SR_TIME_BASE_DEFAULT + 8'd2;

   logic        bus_clk;
   logic        i_reset;
   logic        i_set_stb;
   set_bus_t    i_set;
   sample_t     i_tx_sample;
   logic        i_tx_run;
   sample_t     i_rx;
   sample_t     o_tx;
   sample_t     o_rx_fe;
   radio_time_t o_vita_time;
   logic        o_resp_stb;
   rb_word_t    o_resp;

   integer seed;
   int     errors;
   int     cmds_sent;
   int     cmds_dropped;
   int     resps_seen;

   // Reference model state
   logic                m_set_stb;
   set_bus_t            m_set;
   logic                m_rb_stb;
   logic                m_resp_stb;
   logic                m_loopback;
   logic [31:0]         m_test;
   sample_t             m_codec_idle;
   logic [RB_SEL_W-1:0] m_rb_sel;
   radio_time_t         m_time;
   logic [31:0]         m_time_hi;
   sample_t             m_tx;
   sample_t             m_rx_fe;
   rb_word_t            exp_q[$];

   radio_core dut_i (
      .bus_clk     (bus_clk),
      .i_reset     (i_reset),
      .i_set_stb   (i_set_stb),
      .i_set       (i_set),
      .i_tx_sample (i_tx_sample),
      .i_tx_run    (i_tx_run),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .o_rx_fe     (o_rx_fe),
      .o_vita_time (o_vita_time),
      .o_resp_stb  (o_resp_stb),
      .o_resp      (o_resp)
   );

   bind radio_core radio_core_assertions assertions_i (
      .bus_clk    (bus_clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .o_resp_stb (o_resp_stb)
   );

   initial begin
      bus_clk = 1'b0;
      forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
   end

   // Watchdog sized at 8 cycles per command plus margin
   initial begin
      #((NUM_CMDS * 8 + RESET_CYCLES + 100) * CLK_PERIOD);
      $display("Watchdog expired before all commands were sent and answered");
      $display("SIMULATION FAILED");
      $finish;
   end

   function automatic rb_word_t readback_word(input logic [RB_SEL_W-1:0] sel,
                                              input logic [31:0] test, input radio_time_t t,
                                              input sample_t tx, input sample_t rx);
      rb_word_t w;
      w = '0;
      if (sel == RB_TEST) begin
         w = {32'd0, test};
      end else if (sel == RB_TIME) begin
         w = t;
      end else if (sel == RB_CODEC) begin
         w = {tx, rx};
      end
      return w;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Advances the model by one rising edge with later stages first
   task automatic model_clock_edge();
      m_resp_stb = m_rb_stb;
      if (m_rb_stb) begin
         exp_q.push_back(readback_word(m_rb_sel, m_test, m_time, m_tx, i_rx));
      end
      m_rx_fe = m_loopback ? m_tx : i_rx;
      m_tx    = i_tx_run ? i_tx_sample : m_codec_idle;
      if (m_set_stb && m_set.addr == TIME_LO_ADDR) begin
         m_time = {m_time_hi, m_set.data};
      end else begin
         m_time = m_time + 64'd1;
      end
      if (m_set_stb && m_set.addr == TIME_HI_ADDR) begin
         m_time_hi = m_set.data;
      end else if (m_set_stb && m_set.addr == TIME_CLR_ADDR) begin
         m_time_hi = '0;
      end
      m_rb_stb = m_set_stb;
      if (m_set_stb) begin
         case (m_set.addr)
            SR_LOOPBACK:   m_loopback   = m_set.data[0];
            SR_TEST:       m_test       = m_set.data;
            SR_CODEC_IDLE: m_codec_idle = m_set.data;
            SR_READBACK:   m_rb_sel     = m_set.data[RB_SEL_W-1:0];
            default:       ;
         endcase
      end
      m_set_stb = i_set_stb;
      if (i_set_stb) begin
         m_set = i_set;
      end
   endtask

   // Synchronous reset drops every command still in flight
   task automatic model_reset();
      cmds_dropped = cmds_dropped + int'(i_set_stb) + int'(m_set_stb) + int'(m_rb_stb);
      m_set_stb    = 1'b0;
      m_set        = '0;
      m_rb_stb     = 1'b0;
      m_resp_stb   = 1'b0;
      m_loopback   = 1'b0;
      m_test       = '0;
      m_codec_idle = '0;
      m_rb_sel     = '0;
      m_time       = '0;
      m_time_hi    = '0;
      m_tx         = '0;
      m_rx_fe      = '0;
   endtask

   task automatic check_outputs();
      rb_word_t exp_word;
      check_value("o_resp_stb", {63'd0, o_resp_stb}, {63'd0, m_resp_stb});
      check_value("o_vita_time", o_vita_time, m_time);
      check_value("o_tx", {32'd0, o_tx}, {32'd0, m_tx});
      check_value("o_rx_fe", {32'd0, o_rx_fe}, {32'd0, m_rx_fe});
      if (o_resp_stb === 1'b1) begin
         resps_seen++;
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("Response strobe arrived with no command waiting for it");
         end
         if (exp_q.size() != 0) begin
            exp_word = exp_q.pop_front();
            check_value("o_resp", o_resp, exp_word);
         end
      end
   endtask

   // Commands on three cycles of four with garbage data when idle
   task automatic drive_random_inputs();
      logic [31:0] r;
      logic [31:0] data;
      r    = $random(seed);
      data = $random(seed);
      i_set_stb  = (r[1:0] != 2'b00) && (cmds_sent < NUM_CMDS);
      i_set.data = data;
      case (r[5:2])
         4'd0, 4'd1:       i_set.addr = SR_LOOPBACK;
         4'd2, 4'd3:       i_set.addr = SR_TEST;
         4'd4:             i_set.addr = SR_CODEC_IDLE;
         4'd5, 4'd6, 4'd7: i_set.addr = SR_READBACK;
         4'd8:             i_set.addr = TIME_HI_ADDR;
         4'd9, 4'd10:      i_set.addr = TIME_LO_ADDR;
         4'd11:            i_set.addr = TIME_CLR_ADDR;
         default:          i_set.addr = r[15:8];
      endcase
      i_tx_run    = r[16];
      i_tx_sample = $random(seed);
      i_rx        = $random(seed);
      if (i_set_stb) begin
         cmds_sent++;
      end
   endtask

   task automatic run_cycle();
      @(posedge bus_clk);
      #1;
      if (i_reset) begin
         model_reset();
      end else begin
         model_clock_edge();
      end
      check_outputs();
      drive_random_inputs();
   endtask

   // Reset while the last commands are still in the pipeline
   task automatic reset_mid_run();
      repeat (2) run_cycle();
      i_reset = 1'b1;
      repeat (4) run_cycle();
      i_reset = 1'b0;
   endtask

   initial begin
      seed         = 32'h5991;
      errors       = 0;
      cmds_sent    = 0;
      cmds_dropped = 0;
      resps_seen   = 0;
      i_reset     = 1'b1;
      i_set_stb   = 1'b0;
      i_set       = '0;
      i_tx_sample = '0;
      i_tx_run    = 1'b0;
      i_rx        = '0;
      m_set_stb    = 1'b0;
      m_set        = '0;
      m_rb_stb     = 1'b0;
      m_resp_stb   = 1'b0;
      m_loopback   = 1'b0;
      m_test       = '0;
      m_codec_idle = '0;
      m_rb_sel     = '0;
      m_time       = '0;
      m_time_hi    = '0;
      m_tx         = '0;
      m_rx_fe      = '0;
      repeat (RESET_CYCLES) @(posedge bus_clk);
      #1;
      i_reset = 1'b0;
      while (cmds_sent < NUM_CMDS / 2) begin
         run_cycle();
      end
      reset_mid_run();
      while (cmds_sent < NUM_CMDS) begin
         run_cycle();
      end
      // Let the last commands drain out of the pipeline
      repeat (8) run_cycle();
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d expected responses never arrived", exp_q.size());
      end
      check_value("response count", 64'(resps_seen), 64'(cmds_sent - cmds_dropped));
      $display("Errors: %0d, commands: %0d, dropped: %0d, responses: %0d",
               errors, cmds_sent, cmds_dropped, resps_seen);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: sources.f
src/radio_pkg.sv
src/radio_ctrl_decode.sv
src/radio_settings.sv
src/radio_timekeeper.sv
src/radio_frontend.sv
src/radio_readback.sv
src/radio_core.sv
bench/radio_core_assertions.sv
bench/radio_core_tb.sv

// File: Makefile
# Verilator build and run for the radio control core testbench.
# Override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= radio_core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/10ps -j 0

FILELIST := sources.f
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
